//--- exec_backend.f
logic/rv_core_pkg.sv
logic/exu_wb_if.sv
logic/decode_execute.sv
logic/writeback.sv
logic/exec_backend.sv
testbench/clock_gen.sv
testbench/exec_backend_tb.sv

//--- logic/decode_execute.sv
`timescale 1ns/1ns

module decode_execute (
  input  logic               clk,
  input  logic               rst,
  input  logic               inst_valid,
  output logic               inst_ready,
  input  rv_core_pkg::inst_t inst,
  input  rv_core_pkg::xlen_t inst_pc,
  input  logic               redirect_done,
  exu_wb_if.exu              bus
);
  import rv_core_pkg::*;

  // instruction fields
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] imm12;
  reg_idx_t    rd_idx;
  reg_idx_t    rs1_idx;
  reg_idx_t    rs2_idx;
  csr_addr_t   csr_addr;

  // alu
  xlen_t       imm_i;
  xlen_t       alu_b;
  xlen_t       alu_out;
  logic        alu_ok;
  logic        is_sub;

  // decoded record contents
  logic        dec_wen;
  xlen_t       dec_data;
  logic        dec_csr_wen;
  xlen_t       dec_csr_data;
  logic        dec_ecall;
  logic        dec_mret;

  // handshake and redirect stall
  logic        accept;
  logic        is_trap;
  logic        stall;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign imm12    = inst[31:20];
  assign csr_addr = inst[31:20];
  // upper bit of each 5-bit index dropped
  assign rd_idx   = inst[10:7];
  assign rs1_idx  = inst[18:15];
  assign rs2_idx  = inst[23:20];

  // operand reads go straight to writeback
  assign bus.rs1       = rs1_idx;
  assign bus.rs2       = rs2_idx;
  assign bus.csr_raddr = csr_addr;

  // i-type immediate, sign extended
  assign imm_i  = {{20{imm12[11]}}, imm12};
  // second operand is rs2 for op, immediate otherwise
  assign alu_b  = (opcode == OPC_OP) ? bus.src2 : imm_i;
  assign is_sub = (opcode == OPC_OP) && (funct7 == F7_ALT);

  always_comb begin
    alu_ok = 1'b1;
    case (funct3)
      F3_ADD: alu_out = is_sub ? (bus.src1 - alu_b) : (bus.src1 + alu_b);
      F3_XOR: alu_out = bus.src1 ^ alu_b;
      F3_OR:  alu_out = bus.src1 | alu_b;
      F3_AND: alu_out = bus.src1 & alu_b;
      default: begin
        // slt, shifts etc not supported
        alu_out = '0;
        alu_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    // unknown encodings fall through as no-op
    dec_wen      = 1'b0;
    dec_data     = alu_out;
    dec_csr_wen  = 1'b0;
    dec_csr_data = '0;
    dec_ecall    = 1'b0;
    dec_mret     = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        dec_wen = alu_ok;
      end
      OPC_OP: begin
        // funct7 alt is only legal with add (sub)
        dec_wen = alu_ok &&
                  ((funct7 == F7_BASE) || ((funct7 == F7_ALT) && (funct3 == F3_ADD)));
      end
      OPC_SYSTEM: begin
        case (funct3)
          F3_CSRRW: begin
            // old value to rd, rs1 into csr
            dec_wen      = 1'b1;
            dec_data     = bus.csr_rdata;
            dec_csr_wen  = 1'b1;
            dec_csr_data = bus.src1;
          end
          F3_CSRRS: begin
            dec_wen      = 1'b1;
            dec_data     = bus.csr_rdata;
            // rs1 = x0 means pure read
            dec_csr_wen  = (rs1_idx != '0);
            dec_csr_data = bus.csr_rdata | bus.src1;
          end
          F3_PRIV: begin
            dec_ecall = (imm12 == SYS_ECALL);
            dec_mret  = (imm12 == SYS_MRET);
          end
          default: ;
        endcase
      end
      default: ;
    endcase
    // x0 destination retires as zero
    if (rd_idx == '0) begin
      dec_data = '0;
    end
  end

  assign is_trap = dec_ecall || dec_mret;

  // record slot free and no redirect outstanding
  assign inst_ready = !stall && (!bus.rec_valid || bus.rec_ready);
  assign accept     = inst_valid && inst_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.rec_valid <= 1'b0;
    end else begin
      bus.rec_valid <= accept || (bus.rec_valid && !bus.rec_ready);
    end
  end

  // record payload, loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      bus.rec_pc       <= inst_pc;
      bus.rec_rd       <= rd_idx;
      bus.rec_wen      <= dec_wen;
      bus.rec_data     <= dec_data;
      bus.rec_csr_wen  <= dec_csr_wen;
      bus.rec_csr_addr <= csr_addr;
      bus.rec_csr_data <= dec_csr_data;
      bus.rec_ecall    <= dec_ecall;
      bus.rec_mret     <= dec_mret;
    end
  end

  // stall from ecall/mret accept until the redirect pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      stall <= 1'b0;
    end else if (accept && is_trap) begin
      stall <= 1'b1;
    end else if (redirect_done) begin
      stall <= 1'b0;
    end
  end

endmodule

//--- logic/exec_backend.sv
`timescale 1ns/1ns

module exec_backend (
  input  logic                  clk,
  input  logic                  rst,
  // instruction in from fetch
  input  logic                  inst_valid,
  output logic                  inst_ready,
  input  rv_core_pkg::inst_t    inst,
  input  rv_core_pkg::xlen_t    inst_pc,
  // retire report
  output logic                  retire_valid,
  output rv_core_pkg::xlen_t    retire_pc,
  output logic                  retire_wen,
  output rv_core_pkg::reg_idx_t retire_rd,
  output rv_core_pkg::xlen_t    retire_data,
  // control-flow redirect toward fetch
  output logic                  redirect_valid,
  output rv_core_pkg::xlen_t    redirect_pc
);

  // execute to writeback link
  exu_wb_if bus_if ();

  decode_execute u_exu (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst_ready    (inst_ready),
    .inst          (inst),
    .inst_pc       (inst_pc),
    // redirect pulse releases the stall
    .redirect_done (redirect_valid),
    .bus           (bus_if.exu)
  );

  writeback u_wb (
    .clk            (clk),
    .rst            (rst),
    .bus            (bus_if.wb),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_wen     (retire_wen),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

//--- logic/exu_wb_if.sv
`timescale 1ns/1ns

interface exu_wb_if;
  import rv_core_pkg::*;

  // writeback record
  logic      rec_valid;
  logic      rec_ready;
  xlen_t     rec_pc;
  reg_idx_t  rec_rd;
  logic      rec_wen;
  xlen_t     rec_data;
  logic      rec_csr_wen;
  csr_addr_t rec_csr_addr;
  xlen_t     rec_csr_data;
  logic      rec_ecall;
  logic      rec_mret;

  // combinational operand reads
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  xlen_t     src1;
  xlen_t     src2;
  csr_addr_t csr_raddr;
  xlen_t     csr_rdata;

  modport exu (
    output rec_valid, rec_pc, rec_rd, rec_wen, rec_data,
    output rec_csr_wen, rec_csr_addr, rec_csr_data, rec_ecall, rec_mret,
    input  rec_ready,
    output rs1, rs2, csr_raddr,
    input  src1, src2, csr_rdata
  );

  modport wb (
    input  rec_valid, rec_pc, rec_rd, rec_wen, rec_data,
    input  rec_csr_wen, rec_csr_addr, rec_csr_data, rec_ecall, rec_mret,
    output rec_ready,
    input  rs1, rs2, csr_raddr,
    output src1, src2, csr_rdata
  );

endinterface

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

  // rv32e widths
  localparam int XLEN       = 32;
  localparam int REG_IDX_W  = 4;
  localparam int CSR_ADDR_W = 12;
  // x0..x15 only
  localparam int NUM_REGS   = 16;

  // data word and instruction word
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [31:0]           inst_t;
  // register index, low four bits of the rd/rs fields
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // major opcodes in use
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // alu funct3 (shared by op and op-imm)
  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;

  // system funct3
  localparam logic [2:0] F3_PRIV  = 3'b000;
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  // funct7 for register-register ops
  localparam logic [6:0] F7_BASE  = 7'b0000000;
  // sub only
  localparam logic [6:0] F7_ALT   = 7'b0100000;

  // imm field of the privileged system ops
  localparam logic [11:0] SYS_ECALL = 12'h000;
  localparam logic [11:0] SYS_MRET  = 12'h302;

  // machine-mode csr addresses
  localparam csr_addr_t MSTATUS_ADDR = 12'h300;
  localparam csr_addr_t MTVEC_ADDR   = 12'h305;
  localparam csr_addr_t MEPC_ADDR    = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR  = 12'h342;

  // fixed csr contents
  // mpp = machine
  localparam xlen_t MSTATUS_VALUE = 32'h0000_1800;
  // environment call from m-mode
  localparam xlen_t MCAUSE_VALUE  = 32'd11;

endpackage

//--- logic/writeback.sv
`timescale 1ns/1ns

module writeback (
  input  logic                  clk,
  input  logic                  rst,
  exu_wb_if.wb                  bus,
  output logic                  retire_valid,
  output rv_core_pkg::xlen_t    retire_pc,
  output logic                  retire_wen,
  output rv_core_pkg::reg_idx_t retire_rd,
  output rv_core_pkg::xlen_t    retire_data,
  output logic                  redirect_valid,
  output rv_core_pkg::xlen_t    redirect_pc
);
  import rv_core_pkg::*;

  xlen_t regs [NUM_REGS];
  // writable csrs and their post-commit values
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mtvec_d;
  xlen_t mepc_d;
  logic  xfer;
  logic  rf_fwd;

  function automatic xlen_t csr_read(csr_addr_t addr, xlen_t tvec, xlen_t epc);
    case (addr)
      MSTATUS_ADDR: csr_read = MSTATUS_VALUE;
      MTVEC_ADDR:   csr_read = tvec;
      MEPC_ADDR:    csr_read = epc;
      MCAUSE_ADDR:  csr_read = MCAUSE_VALUE;
      default:      csr_read = '0;
    endcase
  endfunction

  // commit never waits
  assign bus.rec_ready = 1'b1;
  assign xfer          = bus.rec_valid && bus.rec_ready;
  assign rf_fwd        = xfer && bus.rec_wen;

  // register reads with bypass of the record being committed
  assign bus.src1 = (bus.rs1 == '0) ? '0 :
                    (rf_fwd && (bus.rec_rd == bus.rs1)) ? bus.rec_data : regs[bus.rs1];
  assign bus.src2 = (bus.rs2 == '0) ? '0 :
                    (rf_fwd && (bus.rec_rd == bus.rs2)) ? bus.rec_data : regs[bus.rs2];

  always_comb begin
    mtvec_d = mtvec;
    mepc_d  = mepc;
    if (xfer && bus.rec_csr_wen) begin
      // read-only and unknown addresses drop the write
      case (bus.rec_csr_addr)
        MTVEC_ADDR: mtvec_d = bus.rec_csr_data;
        MEPC_ADDR:  mepc_d  = bus.rec_csr_data;
        default: ;
      endcase
    end
    // ecall's own pc wins over a csr write
    if (xfer && bus.rec_ecall) begin
      mepc_d = bus.rec_pc;
    end
  end

  // csr read sees the in-flight commit
  assign bus.csr_rdata = csr_read(bus.csr_raddr, mtvec_d, mepc_d);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_fwd && (bus.rec_rd != '0)) begin
      // x0 never written
      regs[bus.rec_rd] <= bus.rec_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec <= '0;
      mepc  <= '0;
    end else begin
      mtvec <= mtvec_d;
      mepc  <= mepc_d;
    end
  end

  // retire report, one-cycle pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      retire_valid   <= xfer;
      redirect_valid <= xfer && (bus.rec_ecall || bus.rec_mret);
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      retire_pc   <= bus.rec_pc;
      retire_wen  <= bus.rec_wen;
      retire_rd   <= bus.rec_rd;
      retire_data <= bus.rec_data;
      // ecall jumps to trap vector, mret returns to old mepc
      redirect_pc <= bus.rec_ecall ? mtvec_d : mepc;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the exec_backend testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f exec_backend.f --top-module exec_backend_tb -o sim_exec_backend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_exec_backend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1

//--- testbench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over the first 3 rising edges
  initial begin
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- testbench/exec_backend_tb.sv
`timescale 1ns/1ns

module exec_backend_tb;
  import rv_core_pkg::*;

  // instructions per test
  localparam int N_ADDI     = 32;
  localparam int N_ALU      = 20;
  localparam int N_CSR      = 13;
  localparam int N_TRAP     = 9;
  localparam int N_RAND     = 200;
  localparam int MAX_CYCLES = 4 * (N_ADDI + N_ALU + N_CSR + N_TRAP + N_RAND) + 200;

  // one expected retirement
  typedef struct packed {
    xlen_t    pc;
    logic     wen;
    reg_idx_t rd;
    xlen_t    data;
    logic     redir;
    xlen_t    redir_pc;
  } expect_t;

  logic     clk;
  logic     rst;
  logic     inst_valid;
  logic     inst_ready;
  inst_t    inst;
  xlen_t    inst_pc;
  logic     retire_valid;
  xlen_t    retire_pc;
  logic     retire_wen;
  reg_idx_t retire_rd;
  xlen_t    retire_data;
  logic     redirect_valid;
  xlen_t    redirect_pc;

  // reference state
  xlen_t    m_regs [NUM_REGS];
  xlen_t    m_mtvec;
  xlen_t    m_mepc;
  expect_t  exp_q [$];
  logic     trap_pending = 1'b0;
  xlen_t    next_pc;

  int value_errs = 0;
  int proto_errs = 0;
  int stall_errs = 0;
  int run_errs   = 0;
  int cycles     = 0;

  clock_gen clocks (
    .clk (clk),
    .rst (rst)
  );

  exec_backend UUT (
    .clk            (clk),
    .rst            (rst),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_wen     (retire_wen),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  // instruction encoders, 5-bit register fields
  function automatic inst_t i_type(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic inst_t r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                   logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t csr_inst(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                     csr_addr_t addr);
    return {addr, rs1, f3, rd, OPC_SYSTEM};
  endfunction

  function automatic inst_t sys_inst(logic [11:0] imm);
    return {imm, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM};
  endfunction

  function automatic xlen_t alu_ref(logic [2:0] f3, xlen_t a, xlen_t b, logic sub);
    case (f3)
      F3_XOR:  return a ^ b;
      F3_OR:   return a | b;
      F3_AND:  return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  // mstatus and mcause are fixed, unknown addresses read zero
  function automatic xlen_t csr_get(csr_addr_t addr);
    case (addr)
      MSTATUS_ADDR: return 32'h0000_1800;
      MTVEC_ADDR:   return m_mtvec;
      MEPC_ADDR:    return m_mepc;
      MCAUSE_ADDR:  return 32'd11;
      default:      return '0;
    endcase
  endfunction

  function automatic void csr_set(csr_addr_t addr, xlen_t val);
    if (addr == MTVEC_ADDR) begin
      m_mtvec = val;
    end else if (addr == MEPC_ADDR) begin
      m_mepc = val;
    end
  endfunction

  // executes one accepted instruction in program order
  function automatic void run_model(inst_t w, xlen_t pc);
    expect_t    e;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    xlen_t      a;
    xlen_t      old;
    logic       alu_f3;
    f3     = w[14:12];
    f7     = w[31:25];
    rd     = w[10:7];
    rs1    = w[18:15];
    a      = m_regs[rs1];
    alu_f3 = (f3 == F3_ADD) || (f3 == F3_XOR) || (f3 == F3_OR) || (f3 == F3_AND);
    e      = '0;
    e.pc   = pc;
    e.rd   = rd;
    if (w[6:0] == OPC_OP_IMM && alu_f3) begin
      e.wen  = 1'b1;
      e.data = alu_ref(f3, a, {{20{w[31]}}, w[31:20]}, 1'b0);
    end else if (w[6:0] == OPC_OP && alu_f3 &&
                 (f7 == F7_BASE || (f7 == F7_ALT && f3 == F3_ADD))) begin
      e.wen  = 1'b1;
      e.data = alu_ref(f3, a, m_regs[w[23:20]], f7 == F7_ALT);
    end else if (w[6:0] == OPC_SYSTEM && (f3 == F3_CSRRW || f3 == F3_CSRRS)) begin
      // old csr value goes to rd
      old    = csr_get(w[31:20]);
      e.wen  = 1'b1;
      e.data = old;
      if (f3 == F3_CSRRW) begin
        csr_set(w[31:20], a);
      end else if (rs1 != '0) begin
        csr_set(w[31:20], old | a);
      end
    end else if (w[6:0] == OPC_SYSTEM && f3 == F3_PRIV && w[31:20] == SYS_ECALL) begin
      m_mepc     = pc;
      e.redir    = 1'b1;
      e.redir_pc = m_mtvec;
    end else if (w[6:0] == OPC_SYSTEM && f3 == F3_PRIV && w[31:20] == SYS_MRET) begin
      e.redir    = 1'b1;
      e.redir_pc = m_mepc;
    end
    if (e.wen) begin
      if (rd == '0) begin
        e.data = '0;
      end else begin
        m_regs[rd] = e.data;
      end
    end
    exp_q.push_back(e);
  endfunction

  // mix of supported, unsupported and trap encodings
  function automatic inst_t rand_inst();
    logic [31:0] r;
    logic [31:0] s;
    logic [6:0]  f7;
    csr_addr_t   addr;
    r = $urandom;
    s = $urandom;
    case (r[2:0])
      3'd0, 3'd1: return i_type(s[2:0], s[7:3], s[12:8], s[31:20]);
      3'd2, 3'd3: begin
        f7 = r[4] ? F7_ALT : (r[5] ? s[31:25] : F7_BASE);
        return r_type(f7, s[2:0], s[7:3], s[12:8], s[17:13]);
      end
      3'd4: begin
        case (r[5:4])
          2'd0: addr = MTVEC_ADDR;
          2'd1: addr = MEPC_ADDR;
          2'd2: addr = r[6] ? MSTATUS_ADDR : MCAUSE_ADDR;
          2'd3: addr = s[31:20];
        endcase
        // 3'b011 is csrrc, unsupported
        return csr_inst(r[7] ? F3_CSRRS : (r[8] ? F3_CSRRW : 3'b011), s[7:3], s[12:8], addr);
      end
      3'd5: return r[4] ? sys_inst(SYS_ECALL) : sys_inst(SYS_MRET);
      default: return s;
    endcase
  endfunction

  // offer one word and hold it until accepted
  task automatic send_inst(input inst_t word);
    inst_valid <= 1'b1;
    inst       <= word;
    inst_pc    <= next_pc;
    next_pc    = next_pc + 32'd4;
    @(posedge clk);
    while (!inst_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic idle_cycles(input int n);
    inst_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic report_mismatch(input string name, input xlen_t expected, input xlen_t actual);
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    value_errs++;
  endtask

  initial begin
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [31:0] r;
    inst_t       w;
    void'($urandom(32'h853));
    inst_valid <= 1'b0;
    inst       <= '0;
    inst_pc    <= '0;
    next_pc    = 32'h0000_1000;
    wait (rst == 1'b0);
    @(posedge clk);
    if (inst_ready !== 1'b1 || retire_valid !== 1'b0 || redirect_valid !== 1'b0) begin
      $display("ERROR at %0t: outputs not in their reset state after reset", $time);
      run_errs++;
    end

    // all registers read zero, then an addi chain and x0 writes
    for (int i = 1; i < NUM_REGS; i++) begin
      send_inst(i_type(F3_ADD, 5'(i), 5'(i), 12'd0));
    end
    send_inst(i_type(F3_ADD, 5'd1, 5'd0, 12'h7f3));
    for (int i = 2; i < NUM_REGS; i++) begin
      r = $urandom;
      send_inst(i_type(F3_ADD, 5'(i), 5'(i - 1), r[11:0]));
    end
    send_inst(i_type(F3_ADD, 5'd0, 5'd5, 12'h123));
    send_inst(i_type(F3_ADD, 5'd6, 5'd0, 12'd7));

    // dependent r-type chain, valid every cycle
    rs = 5'd15;
    for (int i = 0; i < N_ALU; i++) begin
      r  = $urandom;
      rd = (r[3:0] == 4'd0) ? 5'd1 : {1'b0, r[3:0]};
      case (i % 5)
        0:       w = r_type(F7_BASE, F3_ADD, rd, rs, r[12:8]);
        1:       w = r_type(F7_ALT, F3_ADD, rd, rs, r[12:8]);
        2:       w = r_type(F7_BASE, F3_AND, rd, rs, r[12:8]);
        3:       w = r_type(F7_BASE, F3_OR, rd, rs, r[12:8]);
        default: w = r_type(F7_BASE, F3_XOR, rd, rs, r[12:8]);
      endcase
      send_inst(w);
      rs = rd;
    end

    // csr accesses
    send_inst(csr_inst(F3_CSRRW, 5'd1, 5'd3, MTVEC_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd2, 5'd0, MTVEC_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd4, 5'd5, MTVEC_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd7, 5'd0, MTVEC_ADDR));
    send_inst(csr_inst(F3_CSRRW, 5'd8, 5'd9, MEPC_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd10, 5'd11, MEPC_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd12, 5'd0, MEPC_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd13, 5'd0, MSTATUS_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd14, 5'd0, MCAUSE_ADDR));
    send_inst(csr_inst(F3_CSRRW, 5'd15, 5'd1, MSTATUS_ADDR));
    send_inst(csr_inst(F3_CSRRS, 5'd3, 5'd1, 12'h7c0));
    send_inst(csr_inst(F3_CSRRW, 5'd3, 5'd2, 12'h340));
    send_inst(csr_inst(F3_CSRRS, 5'd3, 5'd0, 12'h340));

    // ecall and mret, next word offered during the stall
    send_inst(i_type(F3_ADD, 5'd5, 5'd0, 12'h100));
    send_inst(csr_inst(F3_CSRRW, 5'd0, 5'd5, MTVEC_ADDR));
    send_inst(sys_inst(SYS_ECALL));
    send_inst(i_type(F3_ADD, 5'd6, 5'd0, 12'd1));
    send_inst(csr_inst(F3_CSRRS, 5'd7, 5'd0, MEPC_ADDR));
    send_inst(sys_inst(SYS_MRET));
    send_inst(i_type(F3_ADD, 5'd8, 5'd0, 12'd2));
    send_inst(sys_inst(SYS_ECALL));
    send_inst(sys_inst(SYS_MRET));

    // random stream with gaps
    for (int i = 0; i < N_RAND; i++) begin
      send_inst(rand_inst());
      r = $urandom;
      if (r[1:0] == 2'd0) begin
        idle_cycles(int'(r[3:2]));
      end
    end

    // latency is two edges, so the queue is empty by now
    idle_cycles(4);
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d expected retirements never arrived", exp_q.size());
      run_errs++;
    end
    $display("errors: %0d value, %0d retire protocol, %0d stall, %0d run",
             value_errs, proto_errs, stall_errs, run_errs);
    if (value_errs == 0 && proto_errs == 0 && stall_errs == 0 && run_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // acceptance side, feeds the model
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        m_regs[i] = '0;
      end
      m_mtvec      = '0;
      m_mepc       = '0;
      trap_pending = 1'b0;
    end else begin
      // ready stays low from trap accept through the redirect pulse
      if (trap_pending && inst_ready) begin
        $display("ERROR at %0t: inst_ready high while a redirect is pending", $time);
        stall_errs++;
      end
      if (redirect_valid) begin
        trap_pending = 1'b0;
      end
      if (inst_valid && inst_ready) begin
        run_model(inst, inst_pc);
        if (exp_q[$].redir) begin
          trap_pending = 1'b1;
        end
      end
    end
  end

  // retire side, compares against the queue
  always @(posedge clk) begin
    expect_t e;
    if (!rst) begin
      if (retire_valid) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: retire_valid high with nothing outstanding", $time);
          proto_errs++;
        end else begin
          e = exp_q.pop_front();
          if (retire_pc !== e.pc) report_mismatch("retire_pc", e.pc, retire_pc);
          if (retire_wen !== e.wen) report_mismatch("retire_wen", 32'(e.wen), 32'(retire_wen));
          if (retire_rd !== e.rd) report_mismatch("retire_rd", 32'(e.rd), 32'(retire_rd));
          // data is only defined for a register write
          if (e.wen && retire_data !== e.data) begin
            report_mismatch("retire_data", e.data, retire_data);
          end
          if (e.redir && redirect_valid !== 1'b1) begin
            report_mismatch("redirect_valid", 32'd1, 32'(redirect_valid));
          end
          if (e.redir && redirect_pc !== e.redir_pc) begin
            report_mismatch("redirect_pc", e.redir_pc, redirect_pc);
          end
          if (!e.redir && redirect_valid !== 1'b0) begin
            $display("ERROR at %0t: redirect_valid high for a non-trap instruction", $time);
            proto_errs++;
          end
        end
      end else if (redirect_valid !== 1'b0) begin
        $display("ERROR at %0t: redirect_valid high without a retirement", $time);
        proto_errs++;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule
